// ==== rtl/control_unit.sv ====
// instruction decoder
`timescale 1ns/1ps

module control_unit (
	input  cpu_types_pkg::opcode_t opcode,
	input  cpu_types_pkg::funct_t func,
	output cpu_types_pkg::aluop_t alu_op,
	output logic alu_src,
	output cpu_types_pkg::ext_t ext_op,
	output logic reg_dst,
	output logic reg_wen,
	output logic jal,
	output logic jump_sel,
	output logic beq,
	output logic bne,
	output logic halt
);
	import cpu_types_pkg::*;

	always_comb begin
		// nop, no write, unless matched below
		alu_op = ALU_ADD;
		alu_src = 1'b0;
		ext_op = EXT_ZERO;
		reg_dst = 1'b0;
		reg_wen = 1'b0;
		jal = 1'b0;
		jump_sel = 1'b0;
		beq = 1'b0;
		bne = 1'b0;
		halt = 1'b0;
		case (opcode)
			RTYPE: begin
				reg_dst = 1'b1;
				reg_wen = 1'b1;
				case (func)
					SLL: alu_op = ALU_SLL;
					ADDU: alu_op = ALU_ADD;
					SUBU: alu_op = ALU_SUB;
					AND: alu_op = ALU_AND;
					OR: alu_op = ALU_OR;
					SLT: alu_op = ALU_SLT;
					// unsupported funct writes nothing
					default: reg_wen = 1'b0;
				endcase
			end
			ADDIU: begin
				alu_src = 1'b1;
				ext_op = EXT_SIGN;
				reg_wen = 1'b1;
			end
			SLTI: begin
				alu_op = ALU_SLT;
				alu_src = 1'b1;
				ext_op = EXT_SIGN;
				reg_wen = 1'b1;
			end
			ANDI: begin
				alu_op = ALU_AND;
				alu_src = 1'b1;
				reg_wen = 1'b1;
			end
			ORI: begin
				alu_op = ALU_OR;
				alu_src = 1'b1;
				reg_wen = 1'b1;
			end
			// rs is r0 in lui, so or passes the upper immediate
			LUI: begin
				alu_op = ALU_OR;
				alu_src = 1'b1;
				ext_op = EXT_UPPER;
				reg_wen = 1'b1;
			end
			// branch offset is signed
			BEQ: begin
				ext_op = EXT_SIGN;
				beq = 1'b1;
			end
			BNE: begin
				ext_op = EXT_SIGN;
				bne = 1'b1;
			end
			J: jump_sel = 1'b1;
			JAL: begin
				jump_sel = 1'b1;
				jal = 1'b1;
				reg_wen = 1'b1;
			end
			HALT: halt = 1'b1;
			default: ;
		endcase
		// opcode comes from a register that reset clears
		a_opcode_known: assert final (!$isunknown(opcode));
	end
endmodule

// ==== rtl/cpu_macros.svh ====
// core widths and sizes
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// datapath word
`define WORD_W 32
// architectural registers
`define REG_COUNT 32
// instruction rom depth in words
`define IMEM_DEPTH 64
// first fetch address
`define RESET_PC 32'h0000_0000

`endif

// ==== rtl/cpu_types_pkg.sv ====
// isa level types
`include "cpu_macros.svh"

package cpu_types_pkg;
	typedef logic [`WORD_W-1:0] word_t;
	typedef logic [4:0] regbits_t;

	// major opcode, instr[31:26]
	typedef enum logic [5:0] {
		RTYPE = 6'b000000,
		J     = 6'b000010,
		JAL   = 6'b000011,
		BEQ   = 6'b000100,
		BNE   = 6'b000101,
		ADDIU = 6'b001001,
		SLTI  = 6'b001010,
		ANDI  = 6'b001100,
		ORI   = 6'b001101,
		LUI   = 6'b001111,
		HALT  = 6'b111111
	} opcode_t;

	// r-type function field, instr[5:0]
	typedef enum logic [5:0] {
		SLL  = 6'b000000,
		ADDU = 6'b100001,
		SUBU = 6'b100011,
		AND  = 6'b100100,
		OR   = 6'b100101,
		SLT  = 6'b101010
	} funct_t;

	typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT, ALU_SLL} aluop_t;

	// how the 16-bit immediate becomes a word
	typedef enum logic [1:0] {EXT_ZERO, EXT_SIGN, EXT_UPPER} ext_t;
endpackage

// ==== rtl/decode_stage.sv ====
// decode stage
`timescale 1ns/1ps

module decode_stage (
	input  logic CLK,
	input  logic nRST,
	input  logic ihit,
	input  pipe_types_pkg::fetch_t fetch_p,
	input  pipe_types_pkg::writeback_t writeback_p,
	output pipe_types_pkg::decode_t decode_p,
	output logic redirect,
	output cpu_types_pkg::word_t target
);
	import cpu_types_pkg::*;
	import pipe_types_pkg::*;

	word_t instr;
	opcode_t opcode;
	funct_t func;
	regbits_t rs;
	regbits_t rt;
	regbits_t rd;
	logic [15:0] imm;
	word_t imm_ext;
	word_t rdat1;
	word_t rdat2;
	aluop_t alu_op;
	logic alu_src;
	ext_t ext_op;
	logic reg_dst;
	logic reg_wen;
	logic jal;
	logic jump_sel;
	logic beq;
	logic bne;
	logic halt;
	logic branch_taken;
	word_t branch_target;
	word_t jump_target;
	decode_t decode_n;

	// field split
	assign instr = fetch_p.instr;
	assign opcode = opcode_t'(instr[31:26]);
	assign func = funct_t'(instr[5:0]);
	assign rs = instr[25:21];
	assign rt = instr[20:16];
	assign rd = instr[15:11];
	assign imm = instr[15:0];

	control_unit i_control_unit (
		.opcode(opcode), .func(func), .alu_op(alu_op), .alu_src(alu_src), .ext_op(ext_op),
		.reg_dst(reg_dst), .reg_wen(reg_wen), .jal(jal), .jump_sel(jump_sel),
		.beq(beq), .bne(bne), .halt(halt)
	);

	// write port fed back from writeback
	register_file i_register_file (
		.CLK(CLK), .nRST(nRST), .wen(writeback_p.valid), .wsel(writeback_p.rw),
		.wdat(writeback_p.data), .rsel1(rs), .rsel2(rt), .rdat1(rdat1), .rdat2(rdat2)
	);

	always_comb begin
		case (ext_op)
			EXT_SIGN: imm_ext = {{16{imm[15]}}, imm};
			EXT_UPPER: imm_ext = {imm, 16'h0000};
			default: imm_ext = {16'h0000, imm};
		endcase
	end

	// early branch resolution, relative to the delay slot address
	assign branch_taken = (beq && rdat1 == rdat2) || (bne && rdat1 != rdat2);
	assign branch_target = fetch_p.npc + {imm_ext[29:0], 2'b00};
	assign jump_target = {fetch_p.npc[31:28], instr[25:0], 2'b00};
	assign redirect = branch_taken || jump_sel;
	assign target = jump_sel ? jump_target : branch_target;

	always_comb begin
		decode_n.alu_op = alu_op;
		decode_n.alu_src = alu_src;
		decode_n.shamt = instr[10:6];
		// link register, rd, or rt
		decode_n.rw = jal ? 5'd31 : (reg_dst ? rd : rt);
		decode_n.reg_wen = reg_wen;
		decode_n.jal = jal;
		decode_n.halt = halt;
		decode_n.npc = fetch_p.npc;
		decode_n.port_a = rdat1;
		decode_n.port_b = rdat2;
		decode_n.imm_ext = imm_ext;
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			decode_p <= '0;
		end else if (ihit) begin
			decode_p <= decode_n;
		end
	end

	// fetch takes a single redirect source
	a_one_transfer: assert property (@(posedge CLK) disable iff (!nRST)
		!(jump_sel && (beq || bne)));
endmodule

// ==== rtl/execute_stage.sv ====
// execute stage
`timescale 1ns/1ps

module execute_stage (
	input  logic CLK,
	input  logic nRST,
	input  logic ihit,
	input  pipe_types_pkg::decode_t decode_p,
	output pipe_types_pkg::writeback_t writeback_p,
	output logic halt
);
	import cpu_types_pkg::*;
	import pipe_types_pkg::*;

	word_t op_b;
	word_t alu_res;
	writeback_t wb_n;
	logic advance;

	// immediate or register operand
	assign op_b = decode_p.alu_src ? decode_p.imm_ext : decode_p.port_b;

	always_comb begin
		case (decode_p.alu_op)
			ALU_ADD: alu_res = decode_p.port_a + op_b;
			ALU_SUB: alu_res = decode_p.port_a - op_b;
			ALU_AND: alu_res = decode_p.port_a & op_b;
			ALU_OR: alu_res = decode_p.port_a | op_b;
			// signed compare for slt and slti
			ALU_SLT: alu_res = ($signed(decode_p.port_a) < $signed(op_b)) ? 32'd1 : 32'd0;
			ALU_SLL: alu_res = decode_p.port_b << decode_p.shamt;
			default: alu_res = '0;
		endcase
	end

	always_comb begin
		// writes to r0 are dropped here
		wb_n.valid = decode_p.reg_wen && (decode_p.rw != '0);
		wb_n.rw = decode_p.rw;
		// jal links the return address
		wb_n.data = decode_p.jal ? decode_p.npc : alu_res;
		wb_n.halt = decode_p.halt;
	end

	// halt is the halt bit of the writeback register
	assign halt = writeback_p.halt;

	// after halt nothing behind it reaches writeback
	assign advance = ihit && !halt;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			writeback_p <= '0;
		end else if (advance) begin
			writeback_p <= wb_n;
		end
	end

	a_halt_sticky: assert property (@(posedge CLK) disable iff (!nRST) halt |=> halt);
endmodule

// ==== rtl/fetch_stage.sv ====
// fetch stage
`timescale 1ns/1ps
`include "cpu_macros.svh"

module fetch_stage (
	input  logic CLK,
	input  logic nRST,
	input  logic ihit,
	input  logic halt,
	input  cpu_types_pkg::word_t imemload,
	input  logic redirect,
	input  cpu_types_pkg::word_t target,
	output cpu_types_pkg::word_t imemaddr,
	output pipe_types_pkg::fetch_t fetch_p
);
	import cpu_types_pkg::*;

	word_t pc;
	word_t npc;
	logic advance;

	// frozen for good once halted
	assign advance = ihit && !halt;
	assign npc = pc + 32'd4;
	assign imemaddr = pc;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			pc <= `RESET_PC;
		end else if (advance) begin
			pc <= redirect ? target : npc;
		end
	end

	// slot after a taken transfer becomes a nop
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			fetch_p <= '0;
		end else if (advance) begin
			if (redirect) begin
				fetch_p <= '0;
			end else begin
				fetch_p.instr <= imemload;
				fetch_p.npc <= npc;
			end
		end
	end

	// targets from decode keep word alignment
	a_imem_aligned: assert property (@(posedge CLK) disable iff (!nRST) imemaddr[1:0] == 2'b00);
endmodule

// ==== rtl/pipe_types_pkg.sv ====
// pipeline register layouts
package pipe_types_pkg;
	import cpu_types_pkg::*;

	// fetch to decode
	typedef struct packed {
		word_t instr;
		// address of the following instruction
		word_t npc;
	} fetch_t;

	// decode to execute
	typedef struct packed {
		aluop_t alu_op;
		// operand b from immediate
		logic alu_src;
		logic [4:0] shamt;
		regbits_t rw;
		logic reg_wen;
		// result is npc, for jal
		logic jal;
		logic halt;
		word_t npc;
		word_t port_a;
		word_t port_b;
		word_t imm_ext;
	} decode_t;

	// execute to register file and outputs
	typedef struct packed {
		// write enable with a nonzero destination
		logic valid;
		regbits_t rw;
		word_t data;
		logic halt;
	} writeback_t;
endpackage

// ==== rtl/pipeline_top.sv ====
// three stage pipeline
`timescale 1ns/1ps

module pipeline_top (
	input  logic CLK,
	input  logic nRST,
	input  logic ihit,
	input  cpu_types_pkg::word_t imemload,
	output cpu_types_pkg::word_t imemaddr,
	output logic wb_valid,
	output cpu_types_pkg::regbits_t wb_reg,
	output cpu_types_pkg::word_t wb_data,
	output logic halt
);
	import cpu_types_pkg::*;
	import pipe_types_pkg::*;

	fetch_t fetch_p;
	decode_t decode_p;
	writeback_t writeback_p;
	// decode back to fetch
	logic redirect;
	word_t target;

	fetch_stage i_fetch_stage (
		.CLK(CLK), .nRST(nRST), .ihit(ihit), .halt(halt), .imemload(imemload),
		.redirect(redirect), .target(target), .imemaddr(imemaddr), .fetch_p(fetch_p)
	);

	decode_stage i_decode_stage (
		.CLK(CLK), .nRST(nRST), .ihit(ihit), .fetch_p(fetch_p),
		.writeback_p(writeback_p), .decode_p(decode_p),
		.redirect(redirect), .target(target)
	);

	execute_stage i_execute_stage (
		.CLK(CLK), .nRST(nRST), .ihit(ihit), .decode_p(decode_p),
		.writeback_p(writeback_p), .halt(halt)
	);

	// writeback ports
	assign wb_valid = writeback_p.valid;
	assign wb_reg = writeback_p.rw;
	assign wb_data = writeback_p.data;
endmodule

// ==== rtl/register_file.sv ====
// register file
`timescale 1ns/1ps
`include "cpu_macros.svh"

module register_file (
	input  logic CLK,
	input  logic nRST,
	input  logic wen,
	input  cpu_types_pkg::regbits_t wsel,
	input  cpu_types_pkg::word_t wdat,
	input  cpu_types_pkg::regbits_t rsel1,
	input  cpu_types_pkg::regbits_t rsel2,
	output cpu_types_pkg::word_t rdat1,
	output cpu_types_pkg::word_t rdat2
);
	import cpu_types_pkg::*;

	word_t regs [`REG_COUNT];
	logic wr_ok;

	// r0 never written, so it stays zero
	assign wr_ok = wen && (wsel != '0);

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			regs <= '{default: '0};
		end else if (wr_ok) begin
			regs[wsel] <= wdat;
		end
	end

	// write data bypasses to a matching read in the same cycle
	always_comb begin
		rdat1 = (wr_ok && wsel == rsel1) ? wdat : regs[rsel1];
		rdat2 = (wr_ok && wsel == rsel2) ? wdat : regs[rsel2];
	end

	a_r0_zero: assert property (@(posedge CLK) disable iff (!nRST) regs[0] == '0);
endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the pipeline testbench with verilator
cd "$(dirname "$0")" &&
verilator --binary --assert --top-module pipeline_tb -f sources.f -o pipeline_sim &&
./obj_dir/pipeline_sim | tee /dev/stderr | grep -x "Done: no errors" > /dev/null &&
{ echo "simulation passed"; exit 0; } || { echo "simulation failed"; exit 1; }

// ==== sources.f ====
+incdir+rtl
rtl/cpu_types_pkg.sv
rtl/pipe_types_pkg.sv
rtl/control_unit.sv
rtl/register_file.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/pipeline_top.sv
tb/pipeline_tb.sv

// ==== tb/pipeline_cases.txt ====
// program words in address order from 0, ffffffff ends the program
// then expected writes in order as register and data pairs, ffffffff ends the list
24010005 2402fffd 34038001 00222021 00222823 0041302a // addiu, ori, addu via write-through, subu, slt
2827ffff 00624024 00854825 00015100 3c0b1234 304cfff0 // slti, and, or, sll, lui, andi
284dfffe 240e0002 00000000 108e0002 // slti negative, setup, nop, beq taken
240f0111 240f0222 // skipped by beq
148e0001 24100033 // bne not taken, next one executes
14220001 24110044 // bne taken, skipped
08000019 24120055 24120066 // j, both skipped
0c00001c 24130077 24130088 // jal, both skipped
24000099 fc000000 // write to r0 never valid, halt
ffffffff
01 00000005 02 fffffffd 03 00008001 04 00000002
05 00000008 06 00000001 07 00000000 08 00008001
09 0000000a 0a 00000050 0b 12340000 0c 0000fff0
0d 00000001 0e 00000002 10 00000033 1f 00000068
ffffffff

// ==== tb/pipeline_tb.sv ====
// pipeline testbench
`timescale 1ns/1ps
`include "cpu_macros.svh"

module pipeline_tb;
	import cpu_types_pkg::*;

	// rom index width, case file size, list terminator
	localparam int ROM_AW = $clog2(`IMEM_DEPTH);
	localparam int CASE_DEPTH = 256;
	localparam word_t END_MARK = 32'hffff_ffff;

	logic CLK = 1'b0;
	logic nRST;
	logic ihit;
	word_t imemload;
	word_t imemaddr;
	logic wb_valid;
	regbits_t wb_reg;
	word_t wb_data;
	logic halt;

	word_t rom [`IMEM_DEPTH];
	word_t case_mem [CASE_DEPTH];
	regbits_t exp_reg [$];
	word_t exp_data [$];
	int n_words;
	int n_seen = 0;
	int write_errors = 0;
	int check_errors = 0;

	pipeline_top i_pipeline_top (
		.CLK(CLK), .nRST(nRST), .ihit(ihit), .imemload(imemload), .imemaddr(imemaddr),
		.wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data), .halt(halt)
	);

	// 20 ns period
	always #10 CLK = ~CLK;

	// instruction memory with no wait states of its own
	assign imemload = rom[imemaddr[ROM_AW+1:2]];

	// compare one retired write against the expected list
	task automatic check_write(input regbits_t rg, input word_t dat);
		assert (!halt) else begin
			$display("register r%0d written after halt", rg);
			write_errors++;
		end
		assert (rg != '0) else begin
			$display("wb_valid raised for a write to r0");
			write_errors++;
		end
		assert (n_seen < exp_reg.size()) else begin
			$display("extra write to r%0d beyond the %0d expected", rg, exp_reg.size());
			write_errors++;
		end
		if (n_seen < exp_reg.size()) begin
			assert (rg == exp_reg[n_seen]) else begin
				$display("FAILED wb_reg expected %h actual %h", exp_reg[n_seen], rg);
				write_errors++;
			end
			assert (dat == exp_data[n_seen]) else begin
				$display("FAILED wb_data expected %h actual %h", exp_data[n_seen], dat);
				write_errors++;
			end
		end
		n_seen++;
	endtask

	// mid cycle, ihit high means the next edge retires this entry
	always @(negedge CLK) begin
		if (nRST && ihit && wb_valid) begin
			check_write(wb_reg, wb_data);
		end
	end

	// random stalls after reset, roughly one cycle in four
	initial begin
		void'($urandom(51529));
		ihit = 1'b0;
		wait (nRST);
		forever begin
			@(posedge CLK);
			#1;
			ihit = ($urandom % 4) != 0;
		end
	end

	initial begin
		int idx;
		int i;
		nRST = 1'b0;
		// unused words write r20 with their index, none may retire after halt
		for (i = 0; i < `IMEM_DEPTH; i++) begin
			rom[i] = {ADDIU, 5'd0, 5'd20, 16'(i)};
		end
		$readmemh("tb/pipeline_cases.txt", case_mem);
		// program words up to the first marker
		idx = 0;
		while (idx < CASE_DEPTH && case_mem[idx] != END_MARK) begin
			if (idx < `IMEM_DEPTH) begin
				rom[idx] = case_mem[idx];
			end
			idx++;
		end
		n_words = idx;
		idx++;
		// register and data pairs up to the second marker
		while (idx + 1 < CASE_DEPTH && case_mem[idx] != END_MARK) begin
			exp_reg.push_back(case_mem[idx][4:0]);
			exp_data.push_back(case_mem[idx + 1]);
			idx += 2;
		end
		assert (n_words > 0 && n_words <= `IMEM_DEPTH && exp_reg.size() > 0) else begin
			$display("cases file gives %0d words and %0d writes, not a usable program",
				n_words, exp_reg.size());
			check_errors++;
		end

		repeat (5) @(posedge CLK);
		// state held by reset
		assert (imemaddr == `RESET_PC) else begin
			$display("FAILED imemaddr expected %h actual %h", `RESET_PC, imemaddr);
			check_errors++;
		end
		assert (!wb_valid) else begin
			$display("FAILED wb_valid expected %h actual %h", 1'b0, wb_valid);
			check_errors++;
		end
		assert (!halt) else begin
			$display("FAILED halt expected %h actual %h", 1'b0, halt);
			check_errors++;
		end
		#1;
		nRST = 1'b1;

		wait (halt);
		// window for any late write
		repeat (8) @(posedge CLK);
		assert (n_seen == exp_reg.size()) else begin
			$display("%0d register writes seen but %0d expected", n_seen, exp_reg.size());
			check_errors++;
		end
		$display("check errors %0d, write errors %0d, writes seen %0d of %0d",
			check_errors, write_errors, n_seen, exp_reg.size());
		if (check_errors + write_errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

	// watchdog, 40 cycles per program word
	initial begin
		int budget;
		@(posedge CLK);
		budget = (n_words + 1) * 40;
		repeat (budget) @(posedge CLK);
		$display("timeout, halt not reached within %0d cycles", budget);
		$display("check errors %0d, write errors %0d, writes seen %0d of %0d",
			check_errors, write_errors, n_seen, exp_reg.size());
		$display("Done: errors found");
		$finish;
	end
endmodule
